// File: common/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath widths and memory sizes
`define MIPS_DATA_W       32
`define MIPS_REG_ADDR_W   5
`define MIPS_IMEM_DEPTH   64
`define MIPS_DMEM_DEPTH   64
`define MIPS_IMEM_ADDR_W  6

// primary opcodes, instr[31:26]
`define MIPS_OP_RTYPE     6'b000000
`define MIPS_OP_ADDI      6'b001000
`define MIPS_OP_LW        6'b100011
`define MIPS_OP_SW        6'b101011
`define MIPS_OP_HALT      6'b111111

// R-type funct codes, instr[5:0]
`define MIPS_FN_ADD       6'b100000
`define MIPS_FN_SUB       6'b100010
`define MIPS_FN_AND       6'b100100
`define MIPS_FN_OR        6'b100101
`define MIPS_FN_SLT       6'b101010

`endif

// File: common/mipsPkg.sv
`default_nettype none

`include "mips_defines.svh"

package mipsPkg;

    // data word, also used for byte addresses
    typedef logic [`MIPS_DATA_W-1:0] wordT;

    // register number
    typedef logic [`MIPS_REG_ADDR_W-1:0] regAddrT;

    typedef logic [`MIPS_DATA_W-1:0] instrT;

    // word index into instruction memory
    typedef logic [`MIPS_IMEM_ADDR_W-1:0] imemAddrT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // where an ALU operand comes from
    typedef enum logic [1:0] {
        fwdReg,
        fwdExMem,
        fwdMemWb
    } fwdSelT;

endpackage

`default_nettype wire

// File: common/hazardIf.sv
`timescale 1ns/1ps
`default_nettype none

interface hazardIf;
    import mipsPkg::*;

    // ID/EX side
    regAddrT idExRs;
    regAddrT idExRt;
    logic    idExMemRd;

    // producers further down the pipe
    regAddrT exMemDst;
    logic    exMemRegWr;
    regAddrT memWbDst;
    logic    memWbRegWr;

    // results of the hazard logic
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    logic    stall;

    modport ctrl (
        input  idExRs, idExRt, idExMemRd, exMemDst, exMemRegWr, memWbDst, memWbRegWr,
        output fwdA, fwdB, stall
    );
    modport dec (output idExRs, idExRt, idExMemRd);
    modport exe (input idExMemRd, fwdA, fwdB, output exMemDst, exMemRegWr);
    modport mem (input exMemDst, exMemRegWr, output memWbDst, memWbRegWr);

endinterface

`default_nettype wire

// File: control/pipeControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module pipeControl (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire mipsPkg::instrT ifIdInstr,
    output logic               fetchEn,
    output mipsPkg::aluOpT     aluOp,
    output logic               aluSrcImm,
    output logic               regDstRt,
    output logic               regWr,
    output logic               memRd,
    output logic               memWr,
    output logic               halt,
    hazardIf.ctrl              hz
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT    rs;
    regAddrT    rt;
    logic       isHalt;
    logic       halted;

    // picks the newest producer of a source register
    function automatic fwdSelT pickFwd(regAddrT src);
        if (hz.exMemRegWr && hz.exMemDst != '0 && hz.exMemDst == src) begin
            return fwdExMem;
        end
        if (hz.memWbRegWr && hz.memWbDst != '0 && hz.memWbDst == src) begin
            return fwdMemWb;
        end
        return fwdReg;
    endfunction

    assign opcode = ifIdInstr[31:26];
    assign funct  = ifIdInstr[5:0];
    assign rs     = ifIdInstr[25:21];
    assign rt     = ifIdInstr[20:16];
    assign isHalt = (opcode == `MIPS_OP_HALT);

    // load-use hazard holds the consumer one cycle in IF/ID
    assign hz.stall = hz.idExMemRd && hz.idExRt != '0 &&
                      (hz.idExRt == rs || hz.idExRt == rt);

    always_comb begin
        hz.fwdA = pickFwd(hz.idExRs);
        hz.fwdB = pickFwd(hz.idExRt);
    end

    // nothing new is fetched once a halt reaches decode
    assign fetchEn = !(hz.stall || halted || isHalt);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halted <= 1'b0;
        end else if (isHalt && !hz.stall) begin
            halted <= 1'b1;
        end
    end

    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        regDstRt  = 1'b0;
        regWr     = 1'b0;
        memRd     = 1'b0;
        memWr     = 1'b0;
        halt      = 1'b0;
        // bubble on stall and inert once halted
        if (!hz.stall && !halted) begin
            unique case (opcode)
                `MIPS_OP_RTYPE: begin
                    regWr = 1'b1;
                    unique case (funct)
                        `MIPS_FN_ADD: aluOp = aluAdd;
                        `MIPS_FN_SUB: aluOp = aluSub;
                        `MIPS_FN_AND: aluOp = aluAnd;
                        `MIPS_FN_OR:  aluOp = aluOr;
                        `MIPS_FN_SLT: aluOp = aluSlt;
                        // unknown funct such as the nop
                        default: regWr = 1'b0;
                    endcase
                end
                `MIPS_OP_ADDI: begin
                    aluSrcImm = 1'b1;
                    regDstRt  = 1'b1;
                    regWr     = 1'b1;
                end
                `MIPS_OP_LW: begin
                    aluSrcImm = 1'b1;
                    regDstRt  = 1'b1;
                    regWr     = 1'b1;
                    memRd     = 1'b1;
                end
                `MIPS_OP_SW: begin
                    aluSrcImm = 1'b1;
                    memWr     = 1'b1;
                end
                `MIPS_OP_HALT: halt = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: fetch/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module fetchStage (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire logic              run,
    input  wire logic              fetchEn,
    input  wire logic              progWrEn,
    input  wire mipsPkg::imemAddrT progAddr,
    input  wire mipsPkg::instrT    progData,
    output mipsPkg::instrT         ifIdInstr
);
    import mipsPkg::*;

    wordT     pc;
    imemAddrT pcIdx;
    instrT    imem [`MIPS_IMEM_DEPTH];
    instrT    fetched;

    assign pcIdx   = pc[`MIPS_IMEM_ADDR_W+1:2];
    assign fetched = imem[pcIdx];

    // program port, only while the core is parked
    always_ff @(posedge clk) begin
        if (progWrEn && !run) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (fetchEn) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID, holds on stall or halt
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifIdInstr <= '0;
        end else if (!run) begin
            ifIdInstr <= '0;
        end else if (fetchEn) begin
            ifIdInstr <= fetched;
        end
    end

endmodule

`default_nettype wire

// File: decode/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module decodeStage (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire mipsPkg::instrT   ifIdInstr,
    input  wire mipsPkg::aluOpT   aluOp,
    input  wire logic             aluSrcImm,
    input  wire logic             regDstRt,
    input  wire logic             regWr,
    input  wire logic             memRd,
    input  wire logic             memWr,
    input  wire logic             halt,
    input  wire logic             wbWr,
    input  wire mipsPkg::regAddrT wbAddr,
    input  wire mipsPkg::wordT    wbData,
    output mipsPkg::wordT         idExA,
    output mipsPkg::wordT         idExB,
    output mipsPkg::wordT         idExImm,
    output mipsPkg::regAddrT      idExDstR,
    output mipsPkg::regAddrT      idExRt,
    output mipsPkg::aluOpT        idExAluOp,
    output logic                  idExAluSrcImm,
    output logic                  idExRegDstRt,
    output logic                  idExRegWr,
    output logic                  idExMemWr,
    output logic                  idExHalt,
    hazardIf.dec                  hz
);
    import mipsPkg::*;

    localparam int NumRegs = 2 ** `MIPS_REG_ADDR_W;

    wordT    regs [NumRegs];
    regAddrT rs;
    regAddrT rt;
    wordT    rdA;
    wordT    rdB;
    wordT    imm;
    regAddrT idExRs;
    logic    idExMemRd;

    // write-first read with $0 hardwired to zero
    function automatic wordT readReg(regAddrT a);
        if (a == '0) begin
            return '0;
        end
        if (wbWr && wbAddr == a) begin
            return wbData;
        end
        return regs[a];
    endfunction

    assign rs  = ifIdInstr[25:21];
    assign rt  = ifIdInstr[20:16];
    assign imm = {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};

    always_comb begin
        rdA = readReg(rs);
        rdB = readReg(rt);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWr && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // ID/EX control and register numbers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idExAluOp     <= aluAdd;
            idExAluSrcImm <= 1'b0;
            idExRegDstRt  <= 1'b0;
            idExRegWr     <= 1'b0;
            idExMemRd     <= 1'b0;
            idExMemWr     <= 1'b0;
            idExHalt      <= 1'b0;
            idExRs        <= '0;
            idExRt        <= '0;
            idExDstR      <= '0;
        end else begin
            idExAluOp     <= aluOp;
            idExAluSrcImm <= aluSrcImm;
            idExRegDstRt  <= regDstRt;
            idExRegWr     <= regWr;
            idExMemRd     <= memRd;
            idExMemWr     <= memWr;
            idExHalt      <= halt;
            idExRs        <= rs;
            idExRt        <= rt;
            idExDstR      <= ifIdInstr[15:11];
        end
    end

    // ID/EX operands
    always_ff @(posedge clk) begin
        idExA   <= rdA;
        idExB   <= rdB;
        idExImm <= imm;
    end

    assign hz.idExRs    = idExRs;
    assign hz.idExRt    = idExRt;
    assign hz.idExMemRd = idExMemRd;

endmodule

`default_nettype wire

// File: execute/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire mipsPkg::wordT    idExA,
    input  wire mipsPkg::wordT    idExB,
    input  wire mipsPkg::wordT    idExImm,
    input  wire mipsPkg::regAddrT idExDstR,
    input  wire mipsPkg::regAddrT idExRt,
    input  wire mipsPkg::aluOpT   idExAluOp,
    input  wire logic             idExAluSrcImm,
    input  wire logic             idExRegDstRt,
    input  wire logic             idExRegWr,
    input  wire logic             idExMemWr,
    input  wire logic             idExHalt,
    input  wire mipsPkg::wordT    memWbData,
    output mipsPkg::wordT         exMemResult,
    output mipsPkg::wordT         exMemStoreData,
    output logic                  exMemMemRd,
    output logic                  exMemMemWr,
    output logic                  exMemHalt,
    hazardIf.exe                  hz
);
    import mipsPkg::*;

    wordT    opA;
    wordT    rtVal;
    wordT    opB;
    wordT    aluOut;
    regAddrT dst;
    regAddrT exMemDst;
    logic    exMemRegWr;

    // forwarded rs
    always_comb begin
        unique case (hz.fwdA)
            fwdExMem: opA = exMemResult;
            fwdMemWb: opA = memWbData;
            default:  opA = idExA;
        endcase
    end

    // forwarded rt, also the store data
    always_comb begin
        unique case (hz.fwdB)
            fwdExMem: rtVal = exMemResult;
            fwdMemWb: rtVal = memWbData;
            default:  rtVal = idExB;
        endcase
    end

    assign opB = idExAluSrcImm ? idExImm : rtVal;
    assign dst = idExRegDstRt ? idExRt : idExDstR;

    always_comb begin
        unique case (idExAluOp)
            aluSub: aluOut = opA - opB;
            aluAnd: aluOut = opA & opB;
            aluOr:  aluOut = opA | opB;
            // signed compare
            aluSlt: aluOut = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
            default: aluOut = opA + opB;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMemDst   <= '0;
            exMemRegWr <= 1'b0;
            exMemMemRd <= 1'b0;
            exMemMemWr <= 1'b0;
            exMemHalt  <= 1'b0;
        end else begin
            exMemDst   <= dst;
            exMemRegWr <= idExRegWr;
            exMemMemRd <= hz.idExMemRd;
            exMemMemWr <= idExMemWr;
            exMemHalt  <= idExHalt;
        end
    end

    // EX/MEM data
    always_ff @(posedge clk) begin
        exMemResult    <= aluOut;
        exMemStoreData <= rtVal;
    end

    assign hz.exMemDst   = exMemDst;
    assign hz.exMemRegWr = exMemRegWr;

endmodule

`default_nettype wire

// File: memory/memStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module memStage (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire mipsPkg::wordT exMemResult,
    input  wire mipsPkg::wordT exMemStoreData,
    input  wire logic          exMemMemRd,
    input  wire logic          exMemMemWr,
    input  wire logic          exMemHalt,
    output logic               wbWr,
    output mipsPkg::regAddrT   wbAddr,
    output mipsPkg::wordT      wbData,
    output logic               memWrEn,
    output mipsPkg::wordT      memAddr,
    output mipsPkg::wordT      memWrData,
    output logic               fin,
    hazardIf.mem               hz
);
    import mipsPkg::*;

    localparam int DmemIdxW = $clog2(`MIPS_DMEM_DEPTH);

    wordT                dmem [`MIPS_DMEM_DEPTH];
    logic [DmemIdxW-1:0] dmemIdx;
    regAddrT             memWbDst;
    logic                memWbRegWr;
    logic                memWbHalt;

    // word addressed, byte offset ignored
    assign dmemIdx = exMemResult[DmemIdxW+1:2];

    always_ff @(posedge clk) begin
        if (exMemMemWr) begin
            dmem[dmemIdx] <= exMemStoreData;
        end
        wbData <= exMemMemRd ? dmem[dmemIdx] : exMemResult;
    end

    // MEM/WB control, fin set as the halt leaves
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWbDst   <= '0;
            memWbRegWr <= 1'b0;
            memWbHalt  <= 1'b0;
            fin        <= 1'b0;
        end else begin
            memWbDst   <= hz.exMemDst;
            memWbRegWr <= hz.exMemRegWr;
            memWbHalt  <= exMemHalt;
            fin        <= fin | memWbHalt;
        end
    end

    assign wbWr          = memWbRegWr;
    assign wbAddr        = memWbDst;
    assign hz.memWbDst   = memWbDst;
    assign hz.memWbRegWr = memWbRegWr;

    // store visible while it sits in EX/MEM
    assign memWrEn   = exMemMemWr;
    assign memAddr   = exMemResult;
    assign memWrData = exMemStoreData;

endmodule

`default_nettype wire

// File: source/mipsPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire logic              run,
    input  wire logic              progWrEn,
    input  wire mipsPkg::imemAddrT progAddr,
    input  wire mipsPkg::instrT    progData,
    output logic                   memWrEn,
    output mipsPkg::wordT          memAddr,
    output mipsPkg::wordT          memWrData,
    output logic                   fin
);
    import mipsPkg::*;

    instrT   ifIdInstr;
    logic    fetchEn;
    aluOpT   aluOp;
    logic    aluSrcImm, regDstRt, regWr, memRd, memWr, halt;
    wordT    idExA, idExB, idExImm;
    regAddrT idExDstR, idExRt;
    aluOpT   idExAluOp;
    logic    idExAluSrcImm, idExRegDstRt, idExRegWr, idExMemWr, idExHalt;
    wordT    exMemResult, exMemStoreData;
    logic    exMemMemRd, exMemMemWr, exMemHalt;
    logic    wbWr;
    regAddrT wbAddr;
    wordT    wbData;

    hazardIf hz ();

    pipeControl pipeControl_i (
        .clk(clk), .arstN(arstN), .ifIdInstr(ifIdInstr), .fetchEn(fetchEn),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm), .regDstRt(regDstRt), .regWr(regWr),
        .memRd(memRd), .memWr(memWr), .halt(halt), .hz(hz.ctrl)
    );

    fetchStage fetchStage_i (
        .clk(clk), .arstN(arstN), .run(run), .fetchEn(fetchEn), .progWrEn(progWrEn),
        .progAddr(progAddr), .progData(progData), .ifIdInstr(ifIdInstr)
    );

    decodeStage decodeStage_i (
        .clk(clk), .arstN(arstN), .ifIdInstr(ifIdInstr), .aluOp(aluOp),
        .aluSrcImm(aluSrcImm), .regDstRt(regDstRt), .regWr(regWr), .memRd(memRd),
        .memWr(memWr), .halt(halt), .wbWr(wbWr), .wbAddr(wbAddr), .wbData(wbData),
        .idExA(idExA), .idExB(idExB), .idExImm(idExImm), .idExDstR(idExDstR),
        .idExRt(idExRt), .idExAluOp(idExAluOp), .idExAluSrcImm(idExAluSrcImm),
        .idExRegDstRt(idExRegDstRt), .idExRegWr(idExRegWr), .idExMemWr(idExMemWr),
        .idExHalt(idExHalt), .hz(hz.dec)
    );

    executeStage executeStage_i (
        .clk(clk), .arstN(arstN), .idExA(idExA), .idExB(idExB), .idExImm(idExImm),
        .idExDstR(idExDstR), .idExRt(idExRt), .idExAluOp(idExAluOp),
        .idExAluSrcImm(idExAluSrcImm), .idExRegDstRt(idExRegDstRt),
        .idExRegWr(idExRegWr), .idExMemWr(idExMemWr), .idExHalt(idExHalt),
        .memWbData(wbData), .exMemResult(exMemResult), .exMemStoreData(exMemStoreData),
        .exMemMemRd(exMemMemRd), .exMemMemWr(exMemMemWr), .exMemHalt(exMemHalt),
        .hz(hz.exe)
    );

    memStage memStage_i (
        .clk(clk), .arstN(arstN), .exMemResult(exMemResult),
        .exMemStoreData(exMemStoreData), .exMemMemRd(exMemMemRd),
        .exMemMemWr(exMemMemWr), .exMemHalt(exMemHalt), .wbWr(wbWr), .wbAddr(wbAddr),
        .wbData(wbData), .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
        .fin(fin), .hz(hz.mem)
    );

endmodule

`default_nettype wire

// File: verif/storeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module storeChecker (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire logic          memWrEn,
    input  wire mipsPkg::wordT memAddr,
    input  wire mipsPkg::wordT memWrData,
    input  wire logic          fin,
    output int                 storeCount,
    output int                 mismatchCount,
    output int                 unexpectedCount,
    output int                 missingCount,
    output int                 finErrCount
);
    import mipsPkg::*;

    // expected stores, oldest first
    string expName [$];
    wordT  expAddr [$];
    wordT  expData [$];

    string curName;
    wordT  curAddr;
    wordT  curData;
    logic  finSeen = 1'b0;
    int    stores = 0;
    int    mismatches = 0;
    int    unexpected = 0;
    int    missing = 0;
    int    finErrs = 0;

    assign storeCount      = stores;
    assign mismatchCount   = mismatches;
    assign unexpectedCount = unexpected;
    assign missingCount    = missing;
    assign finErrCount     = finErrs;

    task automatic expectStore(string name, wordT addr, wordT data);
        expName.push_back(name);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // DUT outputs move on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (arstN && memWrEn) begin
            stores++;
            if (expAddr.size() == 0) begin
                $display("unexpected store of %h to address %h", memWrData, memAddr);
                unexpected++;
            end else begin
                curName = expName.pop_front();
                curAddr = expAddr.pop_front();
                curData = expData.pop_front();
                if (memAddr !== curAddr) begin
                    $display("CHECK FAILED %s address expected %h actual %h",
                             curName, curAddr, memAddr);
                    mismatches++;
                end
                if (memWrData !== curData) begin
                    $display("CHECK FAILED %s data expected %h actual %h",
                             curName, curData, memWrData);
                    mismatches++;
                end
            end
        end
        // fin must come after the last store and then stay up
        if (arstN && fin && !finSeen) begin
            finSeen = 1'b1;
            if (expAddr.size() != 0) begin
                $display("fin rose while %0d expected stores were still outstanding",
                         expAddr.size());
                missing += expAddr.size();
            end
        end else if (finSeen && !fin) begin
            $display("fin dropped low after it had risen");
            finErrs++;
        end
    end

endmodule

`default_nettype wire

// File: verif/tbMipsPipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module tbMipsPipeline;
    import mipsPkg::*;

    localparam int MaxRows = `MIPS_IMEM_DEPTH;

    logic     clk;
    logic     arstN;
    logic     run;
    logic     progWrEn;
    imemAddrT progAddr;
    instrT    progData;
    logic     memWrEn;
    wordT     memAddr;
    wordT     memWrData;
    logic     fin;

    int storeCount;
    int mismatchCount;
    int unexpectedCount;
    int missingCount;
    int finErrCount;
    int timeoutCount = 0;

    // program table
    string rowName [MaxRows];
    instrT rowInstr [MaxRows];
    int    rowCount = 0;

    int seed;
    int cycleLimit = 0;
    int runCycles = 0;

    // architectural state of the reference model
    wordT mRegs [32];
    wordT mMem [`MIPS_DMEM_DEPTH];

    mipsPipeline mipsPipeline_i (
        .clk(clk), .arstN(arstN), .run(run), .progWrEn(progWrEn),
        .progAddr(progAddr), .progData(progData), .memWrEn(memWrEn),
        .memAddr(memAddr), .memWrData(memWrData), .fin(fin)
    );

    storeChecker storeChecker_i (
        .clk(clk), .arstN(arstN), .memWrEn(memWrEn), .memAddr(memAddr),
        .memWrData(memWrData), .fin(fin), .storeCount(storeCount),
        .mismatchCount(mismatchCount), .unexpectedCount(unexpectedCount),
        .missingCount(missingCount), .finErrCount(finErrCount)
    );

    function automatic instrT makeRType(int rd, int rs, int rt, logic [5:0] fn);
        return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    // operand order as in assembly, rt first
    function automatic instrT makeIType(logic [5:0] op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic addRow(string name, instrT instr);
        rowName[rowCount]  = name;
        rowInstr[rowCount] = instr;
        rowCount++;
    endtask

    task automatic buildProgram();
        int immA;
        int immB;
        seed = 35;
        immA = $random(seed) % 30000;
        immB = $random(seed) % 30000;
        // back-to-back dependences through both forwarding paths
        addRow("addi_rand_a", makeIType(`MIPS_OP_ADDI, 1, 0, immA));
        addRow("addi_rand_b", makeIType(`MIPS_OP_ADDI, 2, 0, immB));
        addRow("add_fwd", makeRType(3, 1, 2, `MIPS_FN_ADD));
        addRow("sub_fwd", makeRType(4, 1, 2, `MIPS_FN_SUB));
        addRow("sw_sub", makeIType(`MIPS_OP_SW, 4, 0, 4));
        addRow("sw_add", makeIType(`MIPS_OP_SW, 3, 0, 0));
        // logic ops and slt, both operand orders
        addRow("and_ab", makeRType(5, 1, 2, `MIPS_FN_AND));
        addRow("and_ba", makeRType(6, 2, 1, `MIPS_FN_AND));
        addRow("or_ab", makeRType(7, 1, 2, `MIPS_FN_OR));
        addRow("or_ba", makeRType(8, 2, 1, `MIPS_FN_OR));
        addRow("slt_ab", makeRType(9, 1, 2, `MIPS_FN_SLT));
        addRow("slt_ba", makeRType(10, 2, 1, `MIPS_FN_SLT));
        addRow("addi_neg", makeIType(`MIPS_OP_ADDI, 11, 0, -5));
        addRow("slt_neg_a", makeRType(12, 11, 1, `MIPS_FN_SLT));
        addRow("slt_a_neg", makeRType(13, 1, 11, `MIPS_FN_SLT));
        addRow("sw_and_ab", makeIType(`MIPS_OP_SW, 5, 0, 8));
        addRow("sw_and_ba", makeIType(`MIPS_OP_SW, 6, 0, 12));
        addRow("sw_or_ab", makeIType(`MIPS_OP_SW, 7, 0, 16));
        addRow("sw_or_ba", makeIType(`MIPS_OP_SW, 8, 0, 20));
        addRow("sw_slt_ab", makeIType(`MIPS_OP_SW, 9, 0, 24));
        addRow("sw_slt_ba", makeIType(`MIPS_OP_SW, 10, 0, 28));
        addRow("sw_slt_neg_a", makeIType(`MIPS_OP_SW, 12, 0, 32));
        addRow("sw_slt_a_neg", makeIType(`MIPS_OP_SW, 13, 0, 36));
        // load-use cases off a nonzero base
        addRow("addi_base", makeIType(`MIPS_OP_ADDI, 20, 0, 64));
        addRow("lw_sum", makeIType(`MIPS_OP_LW, 14, 0, 0));
        addRow("add_load_use", makeRType(15, 14, 1, `MIPS_FN_ADD));
        addRow("sw_load_use", makeIType(`MIPS_OP_SW, 15, 20, 8));
        addRow("lw_diff", makeIType(`MIPS_OP_LW, 16, 0, 4));
        addRow("sw_load_store", makeIType(`MIPS_OP_SW, 16, 20, 12));
        addRow("lw_after_sw", makeIType(`MIPS_OP_LW, 17, 20, 12));
        addRow("sub_load_use", makeRType(18, 17, 2, `MIPS_FN_SUB));
        addRow("sw_sub_load", makeIType(`MIPS_OP_SW, 18, 20, 16));
        // $0 stays zero
        addRow("addi_zero", makeIType(`MIPS_OP_ADDI, 0, 0, 77));
        addRow("sw_zero_addi", makeIType(`MIPS_OP_SW, 0, 20, 20));
        addRow("add_zero", makeRType(0, 1, 2, `MIPS_FN_ADD));
        addRow("sw_zero_add", makeIType(`MIPS_OP_SW, 0, 20, 24));
        addRow("halt", {`MIPS_OP_HALT, 26'd0});
    endtask

    // sequential execution of the table, one instruction at a time
    task automatic runModel();
        logic [5:0] op;
        logic [5:0] fn;
        wordT       a;
        wordT       b;
        wordT       imm;
        wordT       addr;
        wordT       res;
        int         rd;
        int         rt;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            mMem[i] = '0;
        end
        for (int i = 0; i < rowCount; i++) begin
            op   = rowInstr[i][31:26];
            fn   = rowInstr[i][5:0];
            rt   = int'(rowInstr[i][20:16]);
            rd   = int'(rowInstr[i][15:11]);
            a    = mRegs[rowInstr[i][25:21]];
            b    = mRegs[rt];
            imm  = {{16{rowInstr[i][15]}}, rowInstr[i][15:0]};
            addr = a + imm;
            if (op == `MIPS_OP_HALT) begin
                break;
            end
            case (op)
                `MIPS_OP_RTYPE: begin
                    case (fn)
                        `MIPS_FN_SUB: res = a - b;
                        `MIPS_FN_AND: res = a & b;
                        `MIPS_FN_OR:  res = a | b;
                        `MIPS_FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
                        default:      res = a + b;
                    endcase
                    if (rd != 0) begin
                        mRegs[rd] = res;
                    end
                end
                `MIPS_OP_ADDI: begin
                    if (rt != 0) begin
                        mRegs[rt] = addr;
                    end
                end
                `MIPS_OP_LW: begin
                    if (rt != 0) begin
                        mRegs[rt] = mMem[addr[7:2]];
                    end
                end
                `MIPS_OP_SW: begin
                    mMem[addr[7:2]] = b;
                    storeChecker_i.expectStore(rowName[i], addr, b);
                end
                default: ;
            endcase
        end
    endtask

    task automatic finishRun();
        int total;
        total = mismatchCount + unexpectedCount + missingCount + finErrCount + timeoutCount;
        $display("stores %0d, mismatch %0d, unexpected %0d, missing %0d, fin %0d, timeout %0d",
                 storeCount, mismatchCount, unexpectedCount, missingCount, finErrCount,
                 timeoutCount);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit, counted from run until fin
    always @(posedge clk) begin
        if (run && !fin) begin
            runCycles++;
            if (runCycles > cycleLimit) begin
                $display("timeout, fin did not rise within %0d cycles of run", cycleLimit);
                timeoutCount++;
                finishRun();
            end
        end
    end

    initial begin
        arstN    <= 1'b0;
        run      <= 1'b0;
        progWrEn <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        buildProgram();
        runModel();
        cycleLimit = 4 * rowCount + 50;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        // program load, one row per cycle while the core is parked
        for (int i = 0; i < rowCount; i++) begin
            @(posedge clk);
            progWrEn <= 1'b1;
            progAddr <= i[5:0];
            progData <= rowInstr[i];
        end
        @(posedge clk);
        progWrEn <= 1'b0;
        run      <= 1'b1;
        while (!fin) begin
            @(posedge clk);
        end
        // a few more cycles to catch a late store or fin dropping
        repeat (8) @(posedge clk);
        finishRun();
    end

endmodule

`default_nettype wire

// File: mipsPipeline.f
+incdir+common
common/mipsPkg.sv
common/hazardIf.sv
control/pipeControl.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
memory/memStage.sv
source/mipsPipeline.sv
verif/storeChecker.sv
verif/tbMipsPipeline.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsPipeline
FILELIST  ?= mipsPipeline.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass text
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
